/* ecc_90.f */
hdl/ecc_pkg.sv
hdl/ecc_check_gen.sv
hdl/ecc_in_stage.sv
hdl/ecc_syndrome_decode.sv
hdl/ecc_out_stage.sv
hdl/ecc_90_top.sv
bench/ecc_90_tb.sv

/* Makefile */
# Verilator flow for the ecc_90 pipeline

TOP := ecc_90_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f ecc_90.f --top-module $(TOP)

obj_dir/V$(TOP): ecc_90.f hdl/*.sv bench/*.sv
	verilator --binary --timing --assert -f ecc_90.f --top-module $(TOP)

# pass only if the run prints the pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

/* bench/ecc_90_tb.sv */
`timescale 1ns/1ps

module ecc_90_tb
    import ecc_pkg::*;
();

    localparam int NUM_STIM    = 28;
    localparam int DRAIN_LIMIT = 50;
    localparam int LATENCY     = 3;

    typedef enum logic [2:0] {
        CLEAN, FLIP_DATA, FLIP_CHECK, FLIP_DATA2, FLIP_DATA_CHECK, FLIP_CHECK2
    } corrupt_e;

    typedef struct packed {
        corrupt_e kind;
        int       a;        // data index, or check index for check flips
        int       b;        // second index of a double flip
        logic     bypass;
    } stim_t;

    typedef struct packed {
        ecc_rsp_t rsp;
        int       in_cyc;
        int       entry;
    } expect_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    ecc_req_t in_req;
    logic     out_valid;
    ecc_rsp_t out_rsp;

    logic [31:0] lfsr;
    int          cyc = 0;
    int          errors;
    int          checked;
    bit          drain_timeout;
    expect_t     exp_q[$];

    stim_t stim_tab [NUM_STIM] = '{
        '{CLEAN,           0,  0,  1'b0},
        '{CLEAN,           0,  0,  1'b0},
        '{FLIP_DATA,       0,  0,  1'b0},
        '{FLIP_DATA,       1,  0,  1'b0},
        '{FLIP_DATA,       45, 0,  1'b0},
        '{FLIP_DATA,       88, 0,  1'b0},
        '{FLIP_DATA,       89, 0,  1'b0},
        '{FLIP_CHECK,      0,  0,  1'b0},
        '{FLIP_CHECK,      1,  0,  1'b0},
        '{FLIP_CHECK,      2,  0,  1'b0},
        '{FLIP_CHECK,      3,  0,  1'b0},
        '{FLIP_CHECK,      4,  0,  1'b0},
        '{FLIP_CHECK,      5,  0,  1'b0},
        '{FLIP_CHECK,      6,  0,  1'b0},
        '{FLIP_CHECK,      7,  0,  1'b0},
        '{FLIP_DATA2,      0,  89, 1'b0},
        '{FLIP_DATA2,      10, 11, 1'b0},
        '{FLIP_DATA2,      1,  2,  1'b0},
        '{FLIP_DATA_CHECK, 5,  3,  1'b0},
        '{FLIP_DATA_CHECK, 89, 7,  1'b0},
        '{FLIP_DATA_CHECK, 0,  0,  1'b0},
        '{FLIP_CHECK2,     0,  7,  1'b0},
        '{FLIP_CHECK2,     3,  4,  1'b0},
        '{CLEAN,           0,  0,  1'b1},
        '{FLIP_DATA,       17, 0,  1'b1},
        '{FLIP_CHECK,      2,  0,  1'b1},
        '{FLIP_DATA2,      30, 60, 1'b1},
        '{CLEAN,           0,  0,  1'b0}
    };

    ecc_90_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return {1'b0, s[31:1]} ^ 32'h80200003;
        end
        return {1'b0, s[31:1]};
    endfunction

    task automatic random_data(output logic [ECC_DATA_W-1:0] d);
        for (int i = 0; i < ECC_DATA_W; i++) begin
            d[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);   // one step per bit
        end
    endtask

    // data bit i goes to the i-th non power of two position from 3 up
    function automatic logic [ECC_CHECK_W-1:0] ref_encode(input logic [ECC_DATA_W-1:0] d);
        logic [ECC_CHECK_W-1:0] c;
        logic [6:0]             pos;
        c   = '0;
        pos = 7'd2;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            pos = pos + 7'd1;
            if ((pos & (pos - 7'd1)) == 7'd0) begin
                pos = pos + 7'd1;   // check bit slot
            end
            if (d[i]) begin
                c[6:0] = c[6:0] ^ pos;
                if ($countones(pos) % 2 == 0) begin
                    c[7] = ~c[7];
                end
            end
        end
        return c;
    endfunction

    task automatic drive_entry(input int n);
        stim_t                 st;
        logic [ECC_DATA_W-1:0] data;
        ecc_req_t              req;
        expect_t               e;
        st = stim_tab[n];
        random_data(data);
        req.data   = data;
        req.parity = ref_encode(data);
        req.bypass = st.bypass;
        case (st.kind)
            FLIP_DATA:  req.data[st.a] = ~req.data[st.a];
            FLIP_CHECK: req.parity[st.a] = ~req.parity[st.a];
            FLIP_DATA2: begin
                req.data[st.a] = ~req.data[st.a];
                req.data[st.b] = ~req.data[st.b];
            end
            FLIP_DATA_CHECK: begin
                req.data[st.a]   = ~req.data[st.a];
                req.parity[st.b] = ~req.parity[st.b];
            end
            FLIP_CHECK2: begin
                req.parity[st.a] = ~req.parity[st.a];
                req.parity[st.b] = ~req.parity[st.b];
            end
            default: ;
        endcase
        e.rsp.parity_out = ref_encode(req.data);
        e.rsp.data       = req.data;   // passed as received unless corrected
        e.rsp.sbit_err   = 1'b0;
        e.rsp.dbit_err   = 1'b0;
        if (!st.bypass) begin
            case (st.kind)
                FLIP_DATA: begin
                    e.rsp.data     = data;
                    e.rsp.sbit_err = 1'b1;
                end
                FLIP_CHECK:                               e.rsp.sbit_err = 1'b1;
                FLIP_DATA2, FLIP_DATA_CHECK, FLIP_CHECK2: e.rsp.dbit_err = 1'b1;
                default: ;
            endcase
        end
        e.in_cyc = cyc;
        e.entry  = n;
        in_valid = 1'b1;
        in_req   = req;
        exp_q.push_back(e);
    endtask

    task automatic check_responses();
        expect_t e;
        forever begin
            @(negedge clk);
            if (!rst && out_valid) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("response at %0t arrived with nothing outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    checked++;
                    assert (out_rsp.data == e.rsp.data) else begin
                        errors++;
                        $display("[FAIL] %0t entry %0d data %h, expected %h",
                                 $time, e.entry, out_rsp.data, e.rsp.data);
                    end
                    assert (out_rsp.parity_out == e.rsp.parity_out) else begin
                        errors++;
                        $display("[FAIL] %0t entry %0d parity_out %h, expected %h",
                                 $time, e.entry, out_rsp.parity_out, e.rsp.parity_out);
                    end
                    assert (out_rsp.sbit_err == e.rsp.sbit_err &&
                            out_rsp.dbit_err == e.rsp.dbit_err) else begin
                        errors++;
                        $display("[FAIL] %0t entry %0d flags s=%b d=%b, expected s=%b d=%b",
                                 $time, e.entry, out_rsp.sbit_err, out_rsp.dbit_err,
                                 e.rsp.sbit_err, e.rsp.dbit_err);
                    end
                    assert (cyc == e.in_cyc + LATENCY) else begin
                        errors++;
                        $display("[FAIL] %0t entry %0d latency %0d cycles, expected %0d",
                                 $time, e.entry, cyc - e.in_cyc, LATENCY);
                    end
                end
            end
        end
    endtask

    task automatic wait_drain(output bit timed_out);
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < DRAIN_LIMIT) begin
            @(negedge clk);
            t++;
        end
        timed_out = (exp_q.size() != 0);
    endtask

    initial begin
        bit timed_out;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_req        = '0;
        lfsr          = 32'h039deaa5;
        errors        = 0;
        checked       = 0;
        drain_timeout = 1'b0;
        fork
            check_responses();
        join_none
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // first pass leaves an idle cycle between words, second runs back to back
        for (int pass = 0; pass < 2; pass++) begin
            for (int n = 0; n < NUM_STIM; n++) begin
                @(negedge clk);
                drive_entry(n);
                if (pass == 0) begin
                    @(negedge clk);
                    in_valid = 1'b0;
                end
            end
            @(negedge clk);
            in_valid = 1'b0;
            wait_drain(timed_out);
            if (timed_out) begin
                drain_timeout = 1'b1;
                $display("timed out waiting for %0d outstanding responses", exp_q.size());
            end
        end
        repeat (LATENCY + 2) @(negedge clk);   // catch stray responses

        $display("responses checked %0d, errors %0d", checked, errors);
        if (errors == 0 && !drain_timeout) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/ecc_90_top.sv */
`timescale 1ns/1ps

module ecc_90_top
    import ecc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  ecc_req_t in_req,
    output logic     out_valid,
    output ecc_rsp_t out_rsp
);

    logic        s1_valid;
    ecc_stage1_t s1;
    logic        s2_valid;
    ecc_stage2_t s2;

    // stage 1, check bit regeneration
    ecc_in_stage u_in_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_req   (in_req),
        .s1_valid (s1_valid),
        .s1       (s1)
    );

    // stage 2, syndrome and error class
    ecc_syndrome_decode u_syndrome_decode (
        .clk      (clk),
        .rst      (rst),
        .s1_valid (s1_valid),
        .s1       (s1),
        .s2_valid (s2_valid),
        .s2       (s2)
    );

    // stage 3, correction and response
    ecc_out_stage u_out_stage (
        .clk       (clk),
        .rst       (rst),
        .s2_valid  (s2_valid),
        .s2        (s2),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

/* hdl/ecc_out_stage.sv */
`timescale 1ns/1ps

module ecc_out_stage
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        s2_valid,
    input  ecc_stage2_t s2,
    output logic        out_valid,
    output ecc_rsp_t    out_rsp
);

    ecc_rsp_t rsp_next;

    always_comb begin
        rsp_next.parity_out = s2.gen;   // always the regenerated bits
        if (s2.bypass) begin
            rsp_next.data     = s2.data;
            rsp_next.sbit_err = 1'b0;
            rsp_next.dbit_err = 1'b0;
        end else begin
            rsp_next.data     = s2.data ^ s2.mask;
            rsp_next.sbit_err = s2.sbit;
            rsp_next.dbit_err = s2.dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            out_rsp <= rsp_next;
        end
    end

    // flags stay exclusive at the boundary, bypass included
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(out_rsp.sbit_err && out_rsp.dbit_err));

endmodule

/* hdl/ecc_syndrome_decode.sv */
`timescale 1ns/1ps

module ecc_syndrome_decode
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        s1_valid,
    input  ecc_stage1_t s1,
    output logic        s2_valid,
    output ecc_stage2_t s2
);

    logic [ECC_CHECK_W-1:0] syndrome;
    logic [ECC_DATA_W-1:0]  mask;
    logic                   check_hit;   // syndrome names a check bit
    logic                   sbit;
    logic                   dbit;

    assign syndrome = s1.parity ^ s1.gen;

    // match against every data column
    always_comb begin
        for (int i = 0; i < ECC_DATA_W; i++) begin
            mask[i] = (syndrome == ecc_column(i));
        end
    end

    assign check_hit = $onehot(syndrome);

    // data columns have odd weight of at least three, so they never
    // collide with a single check bit
    assign sbit = check_hit || (|mask);

    // even weight or a position past the last codeword slot
    assign dbit = (syndrome != '0) &&
                  (!(^syndrome) ||
                   (syndrome[ECC_POS_W-1:0] >= ECC_POS_W'(ECC_DATA_W + ECC_CHECK_W)));

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2.data   <= s1.data;
            s2.gen    <= s1.gen;
            s2.mask   <= mask;
            s2.bypass <= s1.bypass;
            s2.sbit   <= sbit;
            s2.dbit   <= dbit;
        end
    end

    // classification is exclusive for every word leaving this stage
    assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> !(s2.sbit && s2.dbit));

    // a correction flips at most one bit
    assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> $onehot0(s2.mask));

endmodule

/* hdl/ecc_in_stage.sv */
`timescale 1ns/1ps

module ecc_in_stage
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  ecc_req_t    in_req,
    output logic        s1_valid,
    output ecc_stage1_t s1
);

    logic [ECC_CHECK_W-1:0] gen;

    ecc_check_gen u_check_gen (
        .data  (in_req.data),
        .check (gen)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // only place where incoming data is captured
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1.data   <= in_req.data;
            s1.parity <= in_req.parity;
            s1.gen    <= gen;
            s1.bypass <= in_req.bypass;
        end
    end

endmodule

/* hdl/ecc_check_gen.sv */
`timescale 1ns/1ps

module ecc_check_gen
    import ecc_pkg::*;
(
    input  logic [ECC_DATA_W-1:0]  data,
    output logic [ECC_CHECK_W-1:0] check
);

    // Each set data bit flips the check bits named by its column.
    // Summed over all bits this gives, per check bit k, the XOR of the
    // data bits whose column has bit k set.
    always_comb begin
        logic [ECC_CHECK_W-1:0] col;
        check = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            col   = ecc_column(i);
            check = check ^ (col & {ECC_CHECK_W{data[i]}});
        end
    end

endmodule

/* hdl/ecc_pkg.sv */
package ecc_pkg;

    localparam int ECC_DATA_W  = 90;
    localparam int ECC_CHECK_W = 8;
    localparam int ECC_POS_W   = 7;

    // request as seen at the top level
    typedef struct packed {
        logic [ECC_DATA_W-1:0]  data;
        logic [ECC_CHECK_W-1:0] parity;   // received check bits
        logic                   bypass;
    } ecc_req_t;

    typedef struct packed {
        logic [ECC_DATA_W-1:0]  data;
        logic [ECC_CHECK_W-1:0] parity_out; // regenerated from received data
        logic                   sbit_err;
        logic                   dbit_err;
    } ecc_rsp_t;

    typedef struct packed {
        logic [ECC_DATA_W-1:0]  data;
        logic [ECC_CHECK_W-1:0] parity;
        logic [ECC_CHECK_W-1:0] gen;
        logic                   bypass;
    } ecc_stage1_t;

    typedef struct packed {
        logic [ECC_DATA_W-1:0]  data;
        logic [ECC_CHECK_W-1:0] gen;
        logic [ECC_DATA_W-1:0]  mask;     // one-hot flip, zero if nothing to fix
        logic                   bypass;
        logic                   sbit;
        logic                   dbit;
    } ecc_stage2_t;

    // Syndrome column of one data bit. Data sits on the codeword positions
    // that are not powers of two; the low bits are the position itself and
    // the top bit marks even-weight positions, so every column has odd weight.
    function automatic logic [ECC_CHECK_W-1:0] ecc_column(input int idx);
        logic [ECC_POS_W-1:0]   pos;
        logic [ECC_CHECK_W-1:0] col;
        int                     seen;
        pos  = '0;
        seen = 0;
        for (int p = 1; p < ECC_DATA_W + ECC_CHECK_W; p++) begin
            if ((p & (p - 1)) != 0) begin  // skip check bit slots
                if (seen == idx) begin
                    pos = ECC_POS_W'(p);
                end
                seen++;
            end
        end
        col[ECC_CHECK_W-2:0] = pos;
        col[ECC_CHECK_W-1]   = ~^pos;
        return col;
    endfunction

endpackage
